// ==== src/board_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board support layer shared definitions
//   Setup word type and its bit positions
//   Board and game joystick words
//   Game input bundle, DIP bank, clock enables
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package board_pkg;

    // Setup word from the I/O controller, active high fields
    typedef logic [31:0] status_t;

    localparam int ST_PAUSE      = 1;
    localparam int ST_LEVEL_LO   = 2;  // 2 bits, difficulty
    localparam int ST_TEST       = 4;
    localparam int ST_LIVES_LO   = 5;  // 2 bits
    localparam int ST_BONUS_LO   = 7;  // 2 bits
    localparam int ST_INVINCIBLE = 10;
    localparam int ST_RESET      = 15; // Reset request from the OSD

    // {pause, coin, start, b2, b1, up, down, left, right}, active high
    typedef logic [8:0] board_joy_t;

    // Game side joystick, active low, same order as board bits 5:0
    typedef logic [5:0] joy_t;

    typedef struct packed {
        joy_t       joystick1;
        joy_t       joystick2;
        logic [1:0] coin;       // Active low, bit 0 is player 1
        logic [1:0] start;      // Active low
        logic       pause;      // Active high level
    } game_input_t;

    // DIP bank, all fields active low except invincible
    typedef struct packed {
        logic       pause;
        logic [1:0] level;
        logic       test;
        logic       upright;
        logic [1:0] planes;
        logic [2:0] price;
        logic [1:0] bonus;
        logic       invincible;
    } dip_t;

    typedef struct packed {
        logic cen12;
        logic cen6;
        logic cen3;
        logic cen1p5;
    } cen_t;

endpackage

// ==== src/cen_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock enable generator
//   4-bit divider of the pixel clock
//   Nested 12, 6, 3 and 1.5 MHz strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module cen_gen (
    input  logic              clk_rgb,
    input  logic              reset,
    output board_pkg::cen_t   cen
);

    logic [3:0] div_cnt;

    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            div_cnt <= 4'd0;
        end else begin
            div_cnt <= div_cnt + 4'd1; // Free running, wraps every 16
        end
    end

    // Decoded straight from the count, no extra register stage
    always_comb begin
        cen.cen12  = div_cnt[0];
        cen.cen6   = &div_cnt[1:0];
        cen.cen3   = &div_cnt[2:0];
        cen.cen1p5 = &div_cnt;
    end

    // Game logic relies on slower enables landing on faster ones
    a_cen_nested : assert property (
        @(posedge clk_rgb) disable iff (reset)
        (cen.cen6 -> cen.cen12) && (cen.cen3 -> cen.cen6) && (cen.cen1p5 -> cen.cen3)
    ) else $error("cen strobes not nested");

endmodule

// ==== src/system_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// System control
//   Setup word to active-low DIP bank
//   Held game reset
//   Status LED
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module system_ctrl (
    input  logic               clk_rgb,
    input  logic               reset,
    input  board_pkg::status_t status,
    input  logic               downloading,
    input  logic               game_pause,
    output board_pkg::dip_t    dip,
    output logic               game_reset,
    output logic               led
);

    import board_pkg::*;

    // Every switch off, cheat off
    localparam dip_t DIP_IDLE = '{
        pause      : 1'b1,
        level      : 2'b11,
        test       : 1'b1,
        upright    : 1'b1,
        planes     : 2'b11,
        price      : 3'b111,
        bonus      : 2'b11,
        invincible : 1'b0
    };

    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            dip <= DIP_IDLE;
        end else begin
            // OSD pause or player pause both stop the game
            dip.pause      <= ~(status[ST_PAUSE] | game_pause);
            dip.level      <= ~status[ST_LEVEL_LO +: 2];
            dip.test       <= ~status[ST_TEST];
            dip.upright    <= 1'b0;                       // Cocktail cabinet
            dip.planes     <= ~status[ST_LIVES_LO +: 2];
            dip.price      <= 3'b111;                     // 1 coin, 1 credit
            dip.bonus      <= ~status[ST_BONUS_LO +: 2];
            dip.invincible <= status[ST_INVINCIBLE];
        end
    end

    // Game stays in reset while ROMs load or the OSD asks for it
    always_ff @(posedge clk_rgb) begin
        game_reset <= reset | downloading | status[ST_RESET];
        led        <= ~downloading | reset; // Dark only during a download
    end

    a_reset_holds_game : assert property (
        @(posedge clk_rgb) reset |=> game_reset
    ) else $error("game_reset low after system reset");

endmodule

// ==== src/input_mapper.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Input mapper
//   Board joysticks to active-low game inputs
//   Coin and start per player
//   Pause latch toggled by either player
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module input_mapper (
    input  logic                   clk_rgb,
    input  logic                   reset,
    input  board_pkg::board_joy_t  board_joystick1,
    input  board_pkg::board_joy_t  board_joystick2,
    output board_pkg::game_input_t game_in
);

    logic pause_lvl;   // Either player holding pause
    logic pause_prev;
    logic pause_rise;  // Registered press edge

    assign pause_lvl = board_joystick1[8] | board_joystick2[8];

    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            pause_prev <= 1'b0;
            pause_rise <= 1'b0;
        end else begin
            pause_prev <= pause_lvl;
            pause_rise <= pause_lvl & ~pause_prev;
        end
    end

    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            game_in.joystick1 <= '1;
            game_in.joystick2 <= '1;
            game_in.coin      <= 2'b11;
            game_in.start     <= 2'b11;
            game_in.pause     <= 1'b0;
        end else begin
            game_in.joystick1 <= ~board_joystick1[5:0];
            game_in.joystick2 <= ~board_joystick2[5:0];
            game_in.coin      <= ~{board_joystick2[7], board_joystick1[7]};
            game_in.start     <= ~{board_joystick2[6], board_joystick1[6]};
            game_in.pause     <= game_in.pause ^ pause_rise; // Toggle per press
        end
    end

    // A pause flip must trace back to a press two samples earlier
    a_pause_on_press : assert property (
        @(posedge clk_rgb) disable iff (reset)
        $changed(game_in.pause) && !$past(reset) |-> $past(pause_lvl && !pause_prev, 2)
    ) else $error("pause toggled without a press");

endmodule

// ==== src/audio_dac.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Audio DAC
//   First-order sigma-delta modulator
//   Unsigned sample in, one-bit stream out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module audio_dac #(
    parameter int DAC_W = 9
) (
    input  logic             clk_rgb,
    input  logic             reset,
    input  logic [DAC_W-1:0] snd,
    output logic             snd_pwm
);

    logic [DAC_W:0] acc;      // Extra bit holds the carry
    logic [DAC_W:0] acc_next;

    // Carry is dropped each cycle, the residue keeps the error
    assign acc_next = {1'b0, acc[DAC_W-1:0]} + {1'b0, snd};

    always_ff @(posedge clk_rgb) begin
        if (reset) begin
            acc <= '0;
        end else begin
            acc <= acc_next;
        end
    end

    // Ones density tracks snd / 2**DAC_W
    assign snd_pwm = acc[DAC_W];

    a_pwm_known : assert property (
        @(posedge clk_rgb) disable iff (reset)
        !$isunknown(snd_pwm)
    ) else $error("snd_pwm unknown");

endmodule

// ==== src/board_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board support top level
//   Clock enables, system control,
//   input mapping and audio DAC
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module board_top #(
    parameter int DAC_W = 9
) (
    input  logic                   clk_rgb,
    input  logic                   reset,
    input  board_pkg::status_t     status,
    input  logic                   downloading,
    input  board_pkg::board_joy_t  board_joystick1,
    input  board_pkg::board_joy_t  board_joystick2,
    input  logic [DAC_W-1:0]       snd,
    output board_pkg::cen_t        cen,
    output board_pkg::dip_t        dip,
    output logic                   game_reset,
    output board_pkg::game_input_t game_in,
    output logic                   snd_pwm,
    output logic                   led
);

    cen_gen u_cen (
        .clk_rgb     ( clk_rgb       ),
        .reset       ( reset         ),
        .cen         ( cen           )
    );

    system_ctrl u_ctrl (
        .clk_rgb     ( clk_rgb       ),
        .reset       ( reset         ),
        .status      ( status        ),
        .downloading ( downloading   ),
        .game_pause  ( game_in.pause ), // Player pause joins the DIP pause
        .dip         ( dip           ),
        .game_reset  ( game_reset    ),
        .led         ( led           )
    );

    input_mapper u_inputs (
        .clk_rgb         ( clk_rgb         ),
        .reset           ( reset           ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .game_in         ( game_in         )
    );

    audio_dac #(
        .DAC_W       ( DAC_W         )
    ) u_dac (
        .clk_rgb     ( clk_rgb       ),
        .reset       ( reset         ),
        .snd         ( snd           ),
        .snd_pwm     ( snd_pwm       )
    );

endmodule

// ==== verif/board_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board support layer testbench
//   Clock, reset and LFSR stimulus
//   Cycle model of every block
//   Output checks and error counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module board_tb;

    import board_pkg::*;

    logic        clk_rgb;
    logic        reset;
    status_t     status;
    logic        downloading;
    board_joy_t  board_joystick1;
    board_joy_t  board_joystick2;
    logic [8:0]  snd;
    cen_t        cen;
    dip_t        dip;
    logic        game_reset;
    game_input_t game_in;
    logic        snd_pwm;
    logic        led;

    // Values applied after the next rising edge
    logic        nxt_reset;
    status_t     nxt_status;
    logic        nxt_dl;
    board_joy_t  nxt_j1;
    board_joy_t  nxt_j2;
    logic [8:0]  nxt_snd;

    // Model state, as it stands after the latest edge
    logic [3:0]  m_cnt;
    logic [9:0]  m_acc;
    logic        m_prev;           // Pause level seen at the previous edge
    logic        m_press_pending;  // Press seen, flip due next edge
    dip_t        m_dip;
    game_input_t m_gi;
    logic        m_gr;
    logic        m_led;

    logic [15:0] lfsr;
    int          checks;
    int          errors;
    int          timeouts;

    board_top #(.DAC_W(9)) UUT (
        .clk_rgb         ( clk_rgb         ),
        .reset           ( reset           ),
        .status          ( status          ),
        .downloading     ( downloading     ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .snd             ( snd             ),
        .cen             ( cen             ),
        .dip             ( dip             ),
        .game_reset      ( game_reset      ),
        .game_in         ( game_in         ),
        .snd_pwm         ( snd_pwm         ),
        .led             ( led             )
    );

    initial begin
        clk_rgb = 1'b0;
        forever #2 clk_rgb = ~clk_rgb;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    // Register updates on one rising edge, straight from the block rules
    task automatic model_edge();
        logic lvl;
        lvl   = board_joystick1[8] | board_joystick2[8];
        m_gr  = reset | downloading | status[15];
        m_led = ~downloading | reset;
        if (reset) begin
            m_cnt           = 4'd0;
            m_acc           = 10'd0;
            m_prev          = 1'b0;
            m_press_pending = 1'b0;
            m_dip           = '1;
            m_dip.invincible = 1'b0;
            m_gi            = '1;
            m_gi.pause      = 1'b0;
        end else begin
            m_dip.pause      = ~(status[1] | m_gi.pause); // Pause before this edge
            m_dip.level      = ~status[3:2];
            m_dip.test       = ~status[4];
            m_dip.upright    = 1'b0;
            m_dip.planes     = ~status[6:5];
            m_dip.price      = 3'b111;
            m_dip.bonus      = ~status[8:7];
            m_dip.invincible = status[10];
            m_gi.pause       = m_gi.pause ^ m_press_pending;
            m_press_pending  = lvl & ~m_prev;
            m_prev           = lvl;
            m_gi.joystick1   = ~board_joystick1[5:0];
            m_gi.joystick2   = ~board_joystick2[5:0];
            m_gi.coin        = ~{board_joystick2[7], board_joystick1[7]};
            m_gi.start       = ~{board_joystick2[6], board_joystick1[6]};
            m_cnt            = m_cnt + 4'd1;
            m_acc            = {1'b0, m_acc[8:0]} + {1'b0, snd};
        end
    endtask

    task automatic compare_outputs();
        check_val("cen", 32'(cen), {28'd0, m_cnt[0], &m_cnt[1:0], &m_cnt[2:0], &m_cnt});
        check_val("dip", 32'(dip), 32'(m_dip));
        check_val("game_in", 32'(game_in), 32'(m_gi));
        check_val("game_reset", 32'(game_reset), 32'(m_gr));
        check_val("led", 32'(led), 32'(m_led));
        check_val("snd_pwm", 32'(snd_pwm), 32'(m_acc[9]));
    endtask

    // Fixed idle state right after a reset edge
    task automatic check_reset_state();
        check_val("cen after reset", 32'(cen), 32'h0);
        check_val("game_reset after reset", 32'(game_reset), 32'h1);
        check_val("led after reset", 32'(led), 32'h1);
        check_val("dip after reset", 32'(dip), 32'h1FFE);
        check_val("game_in after reset", 32'(game_in), 32'h1FFFE);
        check_val("snd_pwm after reset", 32'(snd_pwm), 32'h0);
    endtask

    // Edge, model update, drive at +1 ns, sample at +3 ns
    task automatic run_cycle();
        @(posedge clk_rgb);
        model_edge();
        #1;
        reset           = nxt_reset;
        status          = nxt_status;
        downloading     = nxt_dl;
        board_joystick1 = nxt_j1;
        board_joystick2 = nxt_j2;
        snd             = nxt_snd;
        #2;
        compare_outputs();
    endtask

    task automatic randomize_inputs();
        logic p1;
        logic p2;
        nxt_status = rand_bits(32);
        nxt_dl     = (rand_bits(4) == 0);  // Rare download
        p1         = (rand_bits(3) == 0);
        p2         = (rand_bits(3) == 0);
        nxt_j1     = {p1, 8'(rand_bits(8))};
        nxt_j2     = {p2, 8'(rand_bits(8))};
    endtask

    task automatic wait_game_released(output logic timed_out);
        int n;
        n = 0;
        timed_out = 1'b0;
        while (game_reset !== 1'b0 && !timed_out) begin
            run_cycle();
            n++;
            if (n >= 16 && game_reset !== 1'b0) begin
                timed_out = 1'b1;
            end
        end
        if (timed_out) begin
            timeouts++;
            $display("Timeout: game_reset stayed high after reset was released");
        end
    endtask

    initial begin
        logic       stuck;
        logic [8:0] level;
        int         dut_ones;
        int         model_ones;
        lfsr     = 16'd13385;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        reset           = 1'b1;
        status          = '0;
        downloading     = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        snd             = '0;
        nxt_status = '0;
        nxt_dl     = 1'b0;
        nxt_j1     = '0;
        nxt_j2     = '0;
        nxt_snd    = '0;

        nxt_reset = 1'b1;
        run_cycle();
        nxt_reset = 1'b0;
        run_cycle();
        check_reset_state();
        wait_game_released(stuck);

        if (!stuck) begin
            for (int i = 0; i < 2000; i++) begin
                if (i % 64 == 0) begin
                    nxt_snd = 9'(rand_bits(9));
                end
                randomize_inputs();
                if (i % 200 == 99) begin
                    nxt_j1[8] = 1'b0;
                    nxt_j2[8] = 1'b0;
                end
                if (i % 200 == 100) begin  // Both players press together
                    nxt_j1[8] = 1'b1;
                    nxt_j2[8] = 1'b1;
                end
                run_cycle();
            end

            // Mid-run reset, then a constant-snd window from a cleared accumulator
            for (int w = 0; w < 4; w++) begin
                level      = 9'(rand_bits(9));
                nxt_snd    = level;
                nxt_reset  = 1'b1;
                randomize_inputs();
                run_cycle();
                nxt_reset  = 1'b0;
                run_cycle();
                check_reset_state();
                dut_ones   = 0;
                model_ones = 0;
                for (int i = 0; i < 512; i++) begin
                    randomize_inputs();
                    run_cycle();
                    dut_ones   += int'(snd_pwm);
                    model_ones += int'(m_acc[9]);
                end
                check_val("snd_pwm ones vs model", 32'(dut_ones), 32'(model_ones));
                check_val("snd_pwm ones vs snd", 32'(dut_ones), 32'(level));
            end
        end

        $display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
src/board_pkg.sv
src/cen_gen.sv
src/system_ctrl.sv
src/input_mapper.sv
src/audio_dac.sv
src/board_top.sv
verif/board_tb.sv

// ==== Makefile ====
# Verilator build for the board support layer

LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module board_top -f sources.f
	verilator --lint-only --timing --assert --top-module board_tb -f sources.f

sim:
	verilator --binary --timing --assert --top-module board_tb -f sources.f -o board_sim
	./obj_dir/board_sim | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
